// File: src/isa_pkg.sv
// ISA package: opcodes, instruction word views and the decoded operation
package isa_pkg;

	// Operand width the instruction set is built around
	localparam int word_width = 16;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		ADC = 4'd1,
		SUB = 4'd2,
		SBC = 4'd3,
		CMP = 4'd4,
		SHR = 4'd5,
		SHL = 4'd6,
		LDF = 4'd7,
		NOP = 4'd8
	} opcode_t;

	// One instruction word, two readings of the bits below the opcode
	typedef union packed {
		struct packed {
			opcode_t     opcode;
			logic [3:0]  shamt;
			logic [7:0]  spare;
		} alu_form;
		struct packed {
			opcode_t     opcode;
			logic [1:0]  group;
			logic [9:0]  spare;
		} ldf_form;
	} instr_u;

	typedef struct packed {
		opcode_t                opcode;
		logic [3:0]             shamt;
		logic [word_width-1:0]  a;
		logic [word_width-1:0]  b;
		logic                   we_zmvc;
		logic                   we_legy;
		logic                   we_x;
		logic                   we_user;
		// Y select for SHR, shares the shift path with X
		logic                   we_y;
	} dec_op_t;

endpackage

// File: src/flags_pkg.sv
// Flags package: R0 status word layout, flag groups and the per-commit update
package flags_pkg;

	// Nine flags on top, user bits below
	localparam int flag_count = 9;
	localparam int user_width = 7;

	typedef struct packed {
		logic                   z;
		logic                   m;
		logic                   v;
		logic                   c;
		logic                   l;
		logic                   e;
		logic                   g;
		logic                   y;
		logic                   x;
		logic [user_width-1:0]  user;
	} r0_word_t;

	typedef enum logic [1:0] {
		ZMVC = 2'd0,
		LEGY = 2'd1,
		X    = 2'd2,
		USER = 2'd3
	} flag_group_t;

	typedef struct packed {
		// Flag values computed by execute
		r0_word_t               cand;
		// Raw word for LDF, user bits come from its low end
		logic [15:0]            load;
		// One bit per flag in R0 order, z first
		logic [flag_count-1:0]  mask;
		logic                   user_we;
		// Take masked flags from load instead of cand
		logic                   from_load;
	} flag_upd_t;

endpackage

// File: src/op_decode.sv
// Decode stage: latches the strobed instruction and derives flag group enables
module op_decode #(
	parameter int data_width = 16
) (
	input  logic                    clk0,
	input  logic                    reset4,
	input  logic                    instr_strobe,
	input  isa_pkg::instr_u         instr,
	input  logic [data_width-1:0]   op_a,
	input  logic [data_width-1:0]   op_b,
	output logic                    dec_strobe,
	output isa_pkg::dec_op_t        dec_op
);

	import isa_pkg::*;
	import flags_pkg::*;

	dec_op_t      dec_next;
	opcode_t      opcode;
	flag_group_t  group;

	// Opcode sits in the same place in both views
	assign opcode = instr.alu_form.opcode;
	assign group  = flag_group_t'(instr.ldf_form.group);

	always_comb begin
		dec_next         = '0;
		dec_next.opcode  = opcode;
		dec_next.a       = op_a;
		dec_next.b       = op_b;
		case (opcode)
			ADD, ADC, SUB, SBC: begin
				dec_next.we_zmvc = 1'b1;
			end
			CMP: begin
				dec_next.we_legy = 1'b1;
			end
			SHR: begin
				dec_next.shamt   = instr.alu_form.shamt;
				dec_next.we_zmvc = 1'b1;
				dec_next.we_y    = 1'b1;
			end
			SHL: begin
				dec_next.shamt   = instr.alu_form.shamt;
				dec_next.we_zmvc = 1'b1;
				dec_next.we_x    = 1'b1;
			end
			LDF: begin
				// Selector names exactly one group
				case (group)
					ZMVC: dec_next.we_zmvc = 1'b1;
					LEGY: dec_next.we_legy = 1'b1;
					X:    dec_next.we_x    = 1'b1;
					USER: dec_next.we_user = 1'b1;
				endcase
			end
			default: begin
				// NOP and unused encodings commit an empty mask
				dec_next.opcode = NOP;
			end
		endcase
	end

	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			dec_strobe <= 1'b0;
		end else begin
			dec_strobe <= instr_strobe;
		end
	end

	// Operation payload only moves with a strobe
	always_ff @(posedge clk0) begin
		if (instr_strobe) begin
			dec_op <= dec_next;
		end
	end

endmodule

// File: src/alu_execute.sv
// Execute stage: arithmetic, compare and shift results with candidate flags
module alu_execute #(
	parameter int data_width = 16
) (
	input  logic                    clk0,
	input  logic                    reset4,
	input  logic                    dec_strobe,
	input  isa_pkg::dec_op_t        dec_op,
	input  flags_pkg::r0_word_t     r0,
	output logic                    exe_strobe,
	output flags_pkg::flag_upd_t    upd,
	output logic [data_width-1:0]   exe_result
);

	import isa_pkg::*;
	import flags_pkg::*;

	logic [data_width-1:0]  a;
	logic [data_width-1:0]  b;
	logic                   cin;
	logic [data_width:0]    arith_ext;
	logic [data_width:0]    shl_ext;
	logic [data_width:0]    shr_ext;
	logic [data_width-1:0]  res;
	logic                   is_shift;
	flag_upd_t              upd_next;

	assign a = dec_op.a;
	assign b = dec_op.b;

	// Carry comes from committed C, no forwarding
	assign cin = (dec_op.opcode == ADC || dec_op.opcode == SBC) ? r0.c : 1'b0;

	// Extra bit above catches carry or borrow
	always_comb begin
		if (dec_op.opcode == SUB || dec_op.opcode == SBC) begin
			arith_ext = {1'b0, a} - {1'b0, b} - {{data_width{1'b0}}, cin};
		end else begin
			arith_ext = {1'b0, a} + {1'b0, b} + {{data_width{1'b0}}, cin};
		end
	end

	// Top bit of shl_ext and bottom bit of shr_ext hold the last bit out
	assign shl_ext = {1'b0, a} << dec_op.shamt;
	assign shr_ext = {a, 1'b0} >> dec_op.shamt;

	assign is_shift = (dec_op.opcode == SHR) || (dec_op.opcode == SHL);

	always_comb begin
		case (dec_op.opcode)
			ADD, ADC, SUB, SBC: res = arith_ext[data_width-1:0];
			SHR:                res = shr_ext[data_width:1];
			SHL:                res = shl_ext[data_width-1:0];
			default:            res = a;
		endcase
	end

	always_comb begin
		upd_next           = '0;
		upd_next.cand.z    = (res == '0);
		upd_next.cand.m    = res[data_width-1];
		upd_next.cand.c    = arith_ext[data_width];
		// Add overflows on like signs, subtract on unlike signs
		if (dec_op.opcode == SUB || dec_op.opcode == SBC) begin
			upd_next.cand.v = (a[data_width-1] != b[data_width-1]) &&
				(res[data_width-1] != a[data_width-1]);
		end else begin
			upd_next.cand.v = (a[data_width-1] == b[data_width-1]) &&
				(res[data_width-1] != a[data_width-1]);
		end
		upd_next.cand.l    = $signed(a) < $signed(b);
		upd_next.cand.e    = (a == b);
		upd_next.cand.g    = $signed(a) > $signed(b);
		upd_next.cand.y    = shr_ext[0];
		upd_next.cand.x    = shl_ext[data_width];
		upd_next.load      = a;
		upd_next.user_we   = dec_op.we_user;
		upd_next.from_load = (dec_op.opcode == LDF);
		// Mask in R0 order: z m v c l e g y x
		upd_next.mask = {
			dec_op.we_zmvc,
			dec_op.we_zmvc,
			dec_op.we_zmvc & ~is_shift,
			dec_op.we_zmvc & ~is_shift,
			dec_op.we_legy,
			dec_op.we_legy,
			dec_op.we_legy,
			dec_op.we_legy | dec_op.we_y,
			dec_op.we_x
		};
	end

	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			exe_strobe <= 1'b0;
		end else begin
			exe_strobe <= dec_strobe;
		end
	end

	always_ff @(posedge clk0) begin
		if (dec_strobe) begin
			upd        <= upd_next;
			exe_result <= res;
		end
	end

endmodule

// File: src/r0_flags.sv
// Result stage: R0 status register with masked per-flag updates and commit strobe
module r0_flags (
	input  logic                  clk0,
	input  logic                  reset4,
	input  logic                  exe_strobe,
	input  flags_pkg::flag_upd_t  upd,
	input  logic [15:0]           exe_result,
	output flags_pkg::r0_word_t   r0,
	output logic                  commit_strobe,
	output logic [15:0]           result
);

	import flags_pkg::*;

	r0_word_t  src;
	r0_word_t  r0_next;

	// LDF writes raw operand bits, everything else the computed flags
	assign src = upd.from_load ? r0_word_t'(upd.load) : upd.cand;

	always_comb begin
		r0_next = r0;
		// Flags occupy the bits above the user field
		for (int i = 0; i < flag_count; i++) begin
			if (upd.mask[i]) begin
				r0_next[user_width + i] = src[user_width + i];
			end
		end
		if (upd.user_we) begin
			r0_next.user = upd.load[user_width-1:0];
		end
	end

	always_ff @(posedge clk0 or negedge reset4) begin
		if (!reset4) begin
			r0            <= '0;
			result        <= '0;
			commit_strobe <= 1'b0;
		end else begin
			commit_strobe <= exe_strobe;
			if (exe_strobe) begin
				r0     <= r0_next;
				result <= exe_result;
			end
		end
	end

endmodule

// File: src/flag_unit_top.sv
// Flag unit top: decode, execute and R0 result stages in a three-cycle pipeline
module flag_unit_top #(
	parameter int data_width = 16
) (
	input  logic                   clk0,
	input  logic                   reset4,
	input  logic                   instr_strobe,
	input  isa_pkg::instr_u        instr,
	input  logic [data_width-1:0]  op_a,
	input  logic [data_width-1:0]  op_b,
	output flags_pkg::r0_word_t    r0,
	output logic                   commit_strobe,
	output logic [15:0]            result
);

	import isa_pkg::*;
	import flags_pkg::*;

	logic                   dec_strobe;
	dec_op_t                dec_op;
	logic                   exe_strobe;
	flag_upd_t              upd;
	logic [data_width-1:0]  exe_result;

	op_decode #(
		.data_width(data_width)
	) u_decode (
		.clk0(clk0),
		.reset4(reset4),
		.instr_strobe(instr_strobe),
		.instr(instr),
		.op_a(op_a),
		.op_b(op_b),
		.dec_strobe(dec_strobe),
		.dec_op(dec_op)
	);

	// Execute reads committed C back from R0
	alu_execute #(
		.data_width(data_width)
	) u_execute (
		.clk0(clk0),
		.reset4(reset4),
		.dec_strobe(dec_strobe),
		.dec_op(dec_op),
		.r0(r0),
		.exe_strobe(exe_strobe),
		.upd(upd),
		.exe_result(exe_result)
	);

	r0_flags u_r0 (
		.clk0(clk0),
		.reset4(reset4),
		.exe_strobe(exe_strobe),
		.upd(upd),
		.exe_result(exe_result),
		.r0(r0),
		.commit_strobe(commit_strobe),
		.result(result)
	);

endmodule

// File: bench/flag_unit_asserts.sv
// R0 stage assertions: commit strobe timing, reset state and masked flag hold
module flag_unit_asserts (
	input logic                  clk0,
	input logic                  reset4,
	input logic                  exe_strobe,
	input flags_pkg::flag_upd_t  upd,
	input flags_pkg::r0_word_t   r0,
	input logic                  commit_strobe
);

	import flags_pkg::*;

	// Commit follows execute by exactly one cycle
	assert property (@(posedge clk0) disable iff (!reset4)
		exe_strobe |=> commit_strobe)
		else $error("commit_strobe did not follow exe_strobe");

	assert property (@(posedge clk0) disable iff (!reset4)
		!exe_strobe |=> !commit_strobe)
		else $error("commit_strobe without exe_strobe");

	// Held in reset means cleared
	assert property (@(posedge clk0)
		(!reset4 && $past(!reset4)) |-> (r0 == '0))
		else $error("r0 not zero during reset");

	// Flag bits outside the write mask keep their value
	assert property (@(posedge clk0) disable iff (!reset4)
		((r0[15:7] ^ $past(r0[15:7])) &
			~($past(upd.mask) & {flag_count{$past(exe_strobe)}})) == '0)
		else $error("unmasked flag changed");

endmodule

bind r0_flags flag_unit_asserts u_asserts (
	.clk0(clk0),
	.reset4(reset4),
	.exe_strobe(exe_strobe),
	.upd(upd),
	.r0(r0),
	.commit_strobe(commit_strobe)
);

// File: bench/flag_unit_checker.sv
// Flag unit checker: reference model of R0, compares every commit against it
module flag_unit_checker (
	input  logic                 clk0,
	input  logic                 reset4,
	input  logic                 instr_strobe,
	input  isa_pkg::instr_u      instr,
	input  logic [15:0]          op_a,
	input  logic [15:0]          op_b,
	input  flags_pkg::r0_word_t  r0,
	input  logic                 commit_strobe,
	input  logic [15:0]          result,
	output int                   tests_done,
	output int                   errors
);

	import isa_pkg::*;
	import flags_pkg::*;

	// Decode, execute and commit each take one edge
	localparam int commit_delay = 3;

	typedef struct packed {
		instr_u       instr;
		logic [15:0]  a;
		logic [15:0]  b;
		int           id;
		int           issue;
	} pend_t;

	pend_t     pend[$];
	r0_word_t  model;
	int        cycle;
	int        next_id;

	function automatic void predict(input pend_t e, input r0_word_t cur,
			output r0_word_t nxt, output logic [15:0] res);
		logic [3:0]   sh;
		logic         cin;
		logic [16:0]  wide;
		logic [15:0]  tmp;
		int           sa;
		int           sb;
		int           si;
		nxt = cur;
		res = e.a;
		sh  = e.instr.alu_form.shamt;
		sa  = $signed(e.a);
		sb  = $signed(e.b);
		cin = cur.c;
		case (e.instr.alu_form.opcode)
			ADD, ADC: begin
				if (e.instr.alu_form.opcode == ADD)
					cin = 1'b0;
				wide  = {1'b0, e.a} + {1'b0, e.b} + {16'd0, cin};
				res   = wide[15:0];
				si    = sa + sb + (cin ? 1 : 0);
				nxt.c = wide[16];
				nxt.v = (si > 32767) || (si < -32768);
				nxt.z = (res == 16'd0);
				nxt.m = res[15];
			end
			SUB, SBC: begin
				if (e.instr.alu_form.opcode == SUB)
					cin = 1'b0;
				res   = e.a - e.b - {15'd0, cin};
				si    = sa - sb - (cin ? 1 : 0);
				// Borrow when b plus borrow-in exceeds a
				nxt.c = ({1'b0, e.a} < ({1'b0, e.b} + {16'd0, cin}));
				nxt.v = (si > 32767) || (si < -32768);
				nxt.z = (res == 16'd0);
				nxt.m = res[15];
			end
			CMP: begin
				nxt.l = (sa < sb);
				nxt.e = (e.a == e.b);
				nxt.g = (sa > sb);
			end
			SHR: begin
				res   = e.a >> sh;
				tmp   = e.a >> (sh - 4'd1);
				nxt.y = (sh == 4'd0) ? 1'b0 : tmp[0];
				nxt.z = (res == 16'd0);
				nxt.m = res[15];
			end
			SHL: begin
				res   = e.a << sh;
				tmp   = e.a << (sh - 4'd1);
				nxt.x = (sh == 4'd0) ? 1'b0 : tmp[15];
				nxt.z = (res == 16'd0);
				nxt.m = res[15];
			end
			LDF: begin
				case (flag_group_t'(e.instr.ldf_form.group))
					ZMVC: {nxt.z, nxt.m, nxt.v, nxt.c} = e.a[15:12];
					LEGY: {nxt.l, nxt.e, nxt.g, nxt.y} = e.a[11:8];
					X:    nxt.x = e.a[7];
					default: nxt.user = e.a[6:0];
				endcase
			end
			default: begin
				nxt = cur;
			end
		endcase
	endfunction

	always @(negedge clk0) begin
		pend_t        e;
		r0_word_t     exp_r0;
		logic [15:0]  exp_res;
		logic         ok;
		if (!reset4) begin
			pend.delete();
			model = '0;
			cycle = 0;
			if (r0 !== '0 || result !== 16'd0 || commit_strobe !== 1'b0) begin
				$display("reset state wrong: r0 %h, result %h, commit_strobe %b",
					r0, result, commit_strobe);
				errors = errors + 1;
			end
		end else begin
			cycle = cycle + 1;
			if (commit_strobe) begin
				if (pend.size() == 0) begin
					$display("unexpected commit with nothing in flight");
					errors = errors + 1;
				end else begin
					e  = pend.pop_front();
					ok = 1'b1;
					predict(e, model, exp_r0, exp_res);
					if (cycle - e.issue != commit_delay) begin
						$display("test %0d committed after %0d samples instead of %0d",
							e.id, cycle - e.issue, commit_delay);
						ok = 1'b0;
					end
					if (r0 !== exp_r0) begin
						$display("MISMATCH r0 test %0d: expected %h, got %h",
							e.id, exp_r0, r0);
						ok = 1'b0;
					end
					if (result !== exp_res) begin
						$display("MISMATCH result test %0d: expected %h, got %h",
							e.id, exp_res, result);
						ok = 1'b0;
					end
					model = exp_r0;
					tests_done = tests_done + 1;
					if (!ok)
						errors = errors + 1;
					$display("test %0d %s: %s", e.id, e.instr.alu_form.opcode.name(),
						ok ? "ok" : "failed");
				end
			end
			// Front entry overdue means its commit never came
			if (pend.size() > 0 && cycle - pend[0].issue > commit_delay) begin
				$display("missing commit for test %0d", pend[0].id);
				void'(pend.pop_front());
				errors = errors + 1;
			end
			if (instr_strobe) begin
				next_id = next_id + 1;
				pend.push_back('{instr: instr, a: op_a, b: op_b, id: next_id, issue: cycle});
			end
		end
	end

	initial begin
		tests_done = 0;
		errors     = 0;
		next_id    = 0;
		cycle      = 0;
		model      = '0;
	end

endmodule

// File: bench/flag_unit_tb.sv
// Flag unit testbench: clock, reset, stimulus table and closing summary
module flag_unit_tb;

	import isa_pkg::*;
	import flags_pkg::*;

	typedef struct packed {
		instr_u       instr;
		logic [15:0]  a;
		logic [15:0]  b;
		// Idle cycles after this entry
		logic [3:0]   gap;
	} stim_t;

	logic             clk0;
	logic             reset4;
	logic             instr_strobe;
	instr_u           instr;
	logic [15:0]      op_a;
	logic [15:0]      op_b;
	r0_word_t         r0;
	logic             commit_strobe;
	logic [15:0]      result;
	int               tests_done;
	int               errors;
	stim_t            stim[$];
	integer           seed;
	int               issued;
	int               t;
	logic             timed_out;

	flag_unit_top #(.data_width(16)) UUT (
		.clk0(clk0), .reset4(reset4), .instr_strobe(instr_strobe), .instr(instr),
		.op_a(op_a), .op_b(op_b), .r0(r0), .commit_strobe(commit_strobe),
		.result(result)
	);

	flag_unit_checker u_checker (
		.clk0(clk0), .reset4(reset4), .instr_strobe(instr_strobe), .instr(instr),
		.op_a(op_a), .op_b(op_b), .r0(r0), .commit_strobe(commit_strobe),
		.result(result), .tests_done(tests_done), .errors(errors)
	);

	always #20 clk0 = ~clk0;

	function automatic instr_u alu_word(input opcode_t op, input logic [3:0] sh);
		instr_u w;
		w = '0;
		w.alu_form.opcode = op;
		w.alu_form.shamt  = sh;
		return w;
	endfunction

	function automatic instr_u ldf_word(input flag_group_t grp);
		instr_u w;
		w = '0;
		w.ldf_form.opcode = LDF;
		w.ldf_form.group  = grp;
		return w;
	endfunction

	task automatic add(input instr_u w, input logic [15:0] a, input logic [15:0] b,
			input logic [3:0] gap);
		stim.push_back('{instr: w, a: a, b: b, gap: gap});
	endtask

	task automatic apply_reset();
		@(posedge clk0);
		reset4       <= 1'b0;
		instr_strobe <= 1'b0;
		repeat (4) @(posedge clk0);
		reset4 <= 1'b1;
	endtask

	// Back-to-back entries keep the strobe high across edges
	task automatic run_stim();
		foreach (stim[i]) begin
			@(posedge clk0);
			instr_strobe <= 1'b1;
			instr        <= stim[i].instr;
			op_a         <= stim[i].a;
			op_b         <= stim[i].b;
			issued       = issued + 1;
			if (stim[i].gap != 4'd0) begin
				@(posedge clk0);
				instr_strobe <= 1'b0;
				repeat (int'(stim[i].gap) - 1) @(posedge clk0);
			end
		end
		@(posedge clk0);
		instr_strobe <= 1'b0;
	endtask

	task automatic wait_commits();
		for (t = 0; t < 200 && tests_done < issued; t++)
			@(posedge clk0);
		if (tests_done < issued) begin
			$display("timeout: %0d of %0d commits seen", tests_done, issued);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		clk0         = 1'b0;
		reset4       = 1'b0;
		instr_strobe = 1'b0;
		instr        = '0;
		op_a         = 16'd0;
		op_b         = 16'd0;
		seed         = 43128;
		issued       = 0;
		timed_out    = 1'b0;

		add(alu_word(NOP, 4'd0), 16'h1234, 16'h0000, 4'd0);
		add(alu_word(ADD, 4'd0), 16'h0001, 16'h0002, 4'd0);
		add(alu_word(ADD, 4'd0), 16'h7fff, 16'h0001, 4'd0);
		// Carry users sit three idle cycles behind any C write
		add(alu_word(ADD, 4'd0), 16'hffff, 16'h0001, 4'd3);
		add(alu_word(ADC, 4'd0), 16'h0001, 16'h0001, 4'd3);
		add(alu_word(SUB, 4'd0), 16'h0005, 16'h0007, 4'd3);
		add(alu_word(SBC, 4'd0), 16'h0010, 16'h0005, 4'd0);
		add(alu_word(SUB, 4'd0), 16'h8000, 16'h0001, 4'd0);
		add(alu_word(SUB, 4'd0), 16'h1234, 16'h1234, 4'd3);
		add(ldf_word(ZMVC), 16'h1000, 16'h0000, 4'd3);
		add(alu_word(SBC, 4'd0), 16'h0000, 16'h0000, 4'd0);
		add(alu_word(CMP, 4'd0), 16'h4321, 16'h4321, 4'd0);
		for (int i = 0; i < 6; i++)
			add(alu_word(CMP, 4'd0), 16'($random(seed)), 16'($random(seed)), 4'd0);
		add(alu_word(SHR, 4'd1), 16'h8001, 16'h0000, 4'd0);
		add(alu_word(SHR, 4'd0), 16'h0003, 16'h0000, 4'd0);
		add(alu_word(SHR, 4'd15), 16'h8000, 16'h0000, 4'd0);
		add(alu_word(SHR, 4'd1), 16'h0001, 16'h0000, 4'd0);
		add(alu_word(SHL, 4'd1), 16'h8001, 16'h0000, 4'd0);
		add(alu_word(SHL, 4'd0), 16'h8001, 16'h0000, 4'd0);
		add(alu_word(SHL, 4'd15), 16'h0001, 16'h0000, 4'd1);
		add(ldf_word(LEGY), 16'h0a00, 16'h0000, 4'd0);
		add(ldf_word(X), 16'h0080, 16'h0000, 4'd0);
		add(ldf_word(USER), 16'h005a, 16'h0000, 4'd0);
		add(ldf_word(ZMVC), 16'hf000, 16'h0000, 4'd0);
		for (int i = 0; i < 4; i++)
			add(alu_word(i[0] ? SUB : ADD, 4'd0), 16'($random(seed)),
				16'($random(seed)), 4'd0);
		add(alu_word(NOP, 4'd0), 16'h00ff, 16'h0000, 4'd0);
		add(alu_word(NOP, 4'd0), 16'hbeef, 16'h0000, 4'd2);

		apply_reset();
		run_stim();
		wait_commits();

		// Second reset, then a short run from the cleared state
		apply_reset();
		stim.delete();
		add(alu_word(NOP, 4'd0), 16'h0000, 16'h0000, 4'd0);
		add(alu_word(ADD, 4'd0), 16'h8000, 16'h8000, 4'd0);
		run_stim();
		wait_commits();
		repeat (4) @(posedge clk0);

		$display("tests %0d of %0d, errors %0d", tests_done, issued, errors);
		if (errors == 0 && !timed_out && tests_done == issued) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: flist.f
src/isa_pkg.sv
src/flags_pkg.sv
src/op_decode.sv
src/alu_execute.sv
src/r0_flags.sv
src/flag_unit_top.sv
bench/flag_unit_asserts.sv
bench/flag_unit_checker.sv
bench/flag_unit_tb.sv

// File: Makefile
SIM  = obj_dir/Vflag_unit_tb
SRCS = $(wildcard src/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) flist.f
	verilator --binary --timing --assert -f flist.f --top-module flag_unit_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1 ; cat sim.log ; grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
